//--- rtl/fp_params.svh
`ifndef FP_PARAMS_SVH
`define FP_PARAMS_SVH

// ----------------------------------------
// Block and FIFO geometry
// ----------------------------------------
`define FP_BLOCK_SIZE 16
`define FP_FIFO_DEPTH 64
// Slack in the input throttle for count latency
`define FP_HEADROOM 4

// Block buffer size in blocks
`define FP_MEM_BLOCKS 4

// ----------------------------------------
// APB register map
// ----------------------------------------
`define FP_REG_CTRL 8'h00
`define FP_REG_STATUS 8'h04

`endif

//--- rtl/host_pkg.sv
package host_pkg;

	// ----------------------------------------
	// APB side of the host interface
	// ----------------------------------------

	// Byte address on the register bus
	typedef logic [7:0] reg_addr_t;

	// Register data word
	typedef logic [31:0] apb_data_t;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

	// ----------------------------------------
	// Data path and block buffer types
	// ----------------------------------------

	typedef logic [31:0] word_t;       // Pipe and buffer word

	// Fill level, 0 to 64 inclusive
	typedef logic [6:0] fifo_count_t;

	typedef logic [1:0] block_idx_t;   // Ring slot in the buffer
	typedef logic [2:0] block_cnt_t;   // Stored blocks, 0 to 4

	// Block mover
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_STORE,                     // Input FIFO to buffer
		DMA_FETCH                      // Buffer to output FIFO
	} dma_state_t;

endpackage

//--- rtl/fifo_sync.sv
`include "fp_params.svh"

module fifo_sync
	import mem_pkg::*;
#(
	parameter int DEPTH = `FP_FIFO_DEPTH
) (
	input  logic        okClk,
	input  logic        rst_n_i,
	input  logic        clear_i,
	input  logic        wr_en_i,
	input  word_t       wr_data_i,
	input  logic        rd_en_i,
	output word_t       rd_data_o,
	output fifo_count_t count_o
);

	// DEPTH is a power of two, so the pointers wrap on their own
	localparam int AW = $clog2(DEPTH);

	word_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign full  = (count_o == fifo_count_t'(DEPTH));
	assign empty = (count_o == '0);
	assign do_wr = wr_en_i && !full;   // Dropped when full
	assign do_rd = rd_en_i && !empty;

	// Show-ahead head word
	assign rd_data_o = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
	end

	always_ff @(posedge okClk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else if (clear_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;   // Both or neither
			endcase
		end
	end

endmodule

//--- rtl/host_regs.sv
`include "fp_params.svh"

module host_regs
	import host_pkg::*;
	import mem_pkg::*;
(
	input  logic        okClk,
	input  logic        rst_n_i,

	// APB slave
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  reg_addr_t   paddr_i,
	input  apb_data_t   pwdata_i,
	output apb_data_t   prdata_o,
	output logic        pready_o,

	// Status sources
	input  fifo_count_t in_count_i,
	input  fifo_count_t out_count_i,
	input  block_cnt_t  blocks_i,

	// Control and throttles
	output logic        reads_en_o,
	output logic        writes_en_o,
	output logic        soft_reset_o,
	output logic        pi_ready_o,
	output logic        po_ready_o
);

	// Room for one more block plus headroom, 44 words
	localparam fifo_count_t PI_LIMIT =
		fifo_count_t'(`FP_FIFO_DEPTH - `FP_HEADROOM - `FP_BLOCK_SIZE);
	localparam fifo_count_t PO_LIMIT = fifo_count_t'(`FP_BLOCK_SIZE);

	logic ctrl_wr;
	apb_data_t ctrl_word;
	apb_data_t status_word;

	// No wait states
	assign pready_o = 1'b1;

	// ----------------------------------------
	// Register decode
	// ----------------------------------------
	assign ctrl_wr = psel_i && penable_i && pwrite_i && (paddr_i == `FP_REG_CTRL);

	assign ctrl_word   = {29'd0, soft_reset_o, writes_en_o, reads_en_o};
	assign status_word = {13'd0, blocks_i, 1'b0, out_count_i, 1'b0, in_count_i};

	always_comb begin
		prdata_o = '0;
		if (psel_i && !pwrite_i) begin
			case (paddr_i)
				`FP_REG_CTRL:   prdata_o = ctrl_word;
				`FP_REG_STATUS: prdata_o = status_word;
				default:        prdata_o = '0;   // Unmapped reads as zero
			endcase
		end
	end

	always_ff @(posedge okClk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			reads_en_o   <= 1'b0;
			writes_en_o  <= 1'b0;
			soft_reset_o <= 1'b0;
		end else if (ctrl_wr) begin
			reads_en_o   <= pwdata_i[0];
			writes_en_o  <= pwdata_i[1];
			soft_reset_o <= pwdata_i[2];
		end
	end

	// ----------------------------------------
	// Block throttles
	// ----------------------------------------
	always_ff @(posedge okClk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pi_ready_o <= 1'b1;   // Empty input FIFO has room
			po_ready_o <= 1'b0;
		end else begin
			pi_ready_o <= (in_count_i <= PI_LIMIT);
			po_ready_o <= (out_count_i >= PO_LIMIT);
		end
	end

endmodule

//--- rtl/dma_engine.sv
`include "fp_params.svh"

module dma_engine
	import mem_pkg::*;
(
	input  logic        okClk,
	input  logic        rst_n_i,
	input  logic        clear_i,
	input  logic        reads_en_i,
	input  logic        writes_en_i,

	// Pipe FIFOs
	input  fifo_count_t in_count_i,
	input  word_t       in_data_i,
	input  fifo_count_t out_count_i,
	output logic        in_rd_o,
	output logic        out_wr_o,
	output word_t       out_data_o,

	// Block buffer
	output logic        mem_we_o,
	output logic [5:0]  mem_waddr_o,
	output word_t       mem_wdata_o,
	output logic [5:0]  mem_raddr_o,
	input  word_t       mem_rdata_i,

	output block_cnt_t  blocks_o
);

	localparam logic [4:0] LAST_WORD = 5'(`FP_BLOCK_SIZE - 1);
	// One extra cycle in a fetch for the buffer read latency
	localparam logic [4:0] FETCH_END = 5'(`FP_BLOCK_SIZE);

	localparam fifo_count_t IN_MIN   = fifo_count_t'(`FP_BLOCK_SIZE);
	localparam fifo_count_t OUT_MAX  = fifo_count_t'(`FP_FIFO_DEPTH - `FP_BLOCK_SIZE);
	localparam block_cnt_t  BUF_FULL = block_cnt_t'(`FP_MEM_BLOCKS);

	dma_state_t state;
	logic [4:0] word_cnt;
	block_idx_t wr_blk;   // Next slot to fill
	block_idx_t rd_blk;   // Oldest stored slot
	logic store_go;
	logic fetch_go;

	// ----------------------------------------
	// Start rules
	// ----------------------------------------
	assign store_go = writes_en_i && (in_count_i >= IN_MIN) && (blocks_o < BUF_FULL);
	assign fetch_go = reads_en_i && (blocks_o != '0) && (out_count_i <= OUT_MAX);

	// Store path, one word per cycle from the FIFO head
	assign in_rd_o     = (state == DMA_STORE);
	assign mem_we_o    = (state == DMA_STORE);
	assign mem_waddr_o = {wr_blk, word_cnt[3:0]};
	assign mem_wdata_o = in_data_i;

	// Fetch path, write trails the address by one cycle
	assign mem_raddr_o = {rd_blk, word_cnt[3:0]};
	assign out_wr_o    = (state == DMA_FETCH) && (word_cnt != '0);
	assign out_data_o  = mem_rdata_i;

	always_ff @(posedge okClk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= DMA_IDLE;
			word_cnt <= '0;
			wr_blk   <= '0;
			rd_blk   <= '0;
			blocks_o <= '0;
		end else if (clear_i) begin
			state    <= DMA_IDLE;
			word_cnt <= '0;
			wr_blk   <= '0;
			rd_blk   <= '0;
			blocks_o <= '0;
		end else begin
			case (state)
				DMA_IDLE: begin
					word_cnt <= '0;
					if (store_go)
						state <= DMA_STORE;   // Store wins over fetch
					else if (fetch_go)
						state <= DMA_FETCH;
				end

				DMA_STORE: begin
					word_cnt <= word_cnt + 5'd1;
					if (word_cnt == LAST_WORD) begin
						state    <= DMA_IDLE;
						wr_blk   <= wr_blk + 2'd1;
						blocks_o <= blocks_o + 3'd1;
					end
				end

				DMA_FETCH: begin
					word_cnt <= word_cnt + 5'd1;
					// Slot counted free on the first word
					if (word_cnt == '0)
						blocks_o <= blocks_o - 3'd1;
					// Read pointer holds until the last write lands
					if (word_cnt == FETCH_END) begin
						state  <= DMA_IDLE;
						rd_blk <= rd_blk + 2'd1;
					end
				end

				default: state <= DMA_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/block_ram.sv
`include "fp_params.svh"

module block_ram
	import mem_pkg::*;
(
	input  logic       okClk,
	input  logic       we_i,
	input  logic [5:0] waddr_i,   // {block, word}
	input  word_t      wdata_i,
	input  logic [5:0] raddr_i,
	output word_t      rdata_o
);

	localparam int DEPTH = `FP_MEM_BLOCKS * `FP_BLOCK_SIZE;

	word_t mem [DEPTH];

	always_ff @(posedge okClk) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Data one cycle after the address
	always_ff @(posedge okClk) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

//--- rtl/pipe_top.sv
`include "fp_params.svh"

module pipe_top
	import host_pkg::*;
	import mem_pkg::*;
(
	input  logic      okClk,
	input  logic      rst_n_i,

	// APB register port
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  reg_addr_t paddr_i,
	input  apb_data_t pwdata_i,
	output apb_data_t prdata_o,
	output logic      pready_o,

	// Host pipes
	input  logic      pi_write_i,
	input  word_t     pi_data_i,
	input  logic      po_read_i,
	output logic      pi_ready_o,
	output word_t     po_data_o,
	output logic      po_ready_o
);

	logic        reads_en;
	logic        writes_en;
	logic        soft_reset;

	logic        in_rd;
	word_t       in_data;
	fifo_count_t in_count;

	logic        out_wr;
	word_t       out_data;
	fifo_count_t out_count;

	logic        mem_we;
	logic [5:0]  mem_waddr;
	word_t       mem_wdata;
	logic [5:0]  mem_raddr;
	word_t       mem_rdata;
	block_cnt_t  blocks;

	// ----------------------------------------
	// Control and status
	// ----------------------------------------
	host_regs u_host_regs (
		.okClk        (okClk),
		.rst_n_i      (rst_n_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.in_count_i   (in_count),
		.out_count_i  (out_count),
		.blocks_i     (blocks),
		.reads_en_o   (reads_en),
		.writes_en_o  (writes_en),
		.soft_reset_o (soft_reset),
		.pi_ready_o   (pi_ready_o),
		.po_ready_o   (po_ready_o)
	);

	// ----------------------------------------
	// Pipe FIFOs
	// ----------------------------------------
	fifo_sync #(.DEPTH(`FP_FIFO_DEPTH)) u_pipe_in (
		.okClk     (okClk),
		.rst_n_i   (rst_n_i),
		.clear_i   (soft_reset),
		.wr_en_i   (pi_write_i),   // Host side
		.wr_data_i (pi_data_i),
		.rd_en_i   (in_rd),        // DMA side
		.rd_data_o (in_data),
		.count_o   (in_count)
	);

	fifo_sync #(.DEPTH(`FP_FIFO_DEPTH)) u_pipe_out (
		.okClk     (okClk),
		.rst_n_i   (rst_n_i),
		.clear_i   (soft_reset),
		.wr_en_i   (out_wr),
		.wr_data_i (out_data),
		.rd_en_i   (po_read_i),
		.rd_data_o (po_data_o),
		.count_o   (out_count)
	);

	// ----------------------------------------
	// Block mover and buffer
	// ----------------------------------------
	dma_engine u_dma (
		.okClk       (okClk),
		.rst_n_i     (rst_n_i),
		.clear_i     (soft_reset),
		.reads_en_i  (reads_en),
		.writes_en_i (writes_en),
		.in_count_i  (in_count),
		.in_data_i   (in_data),
		.out_count_i (out_count),
		.in_rd_o     (in_rd),
		.out_wr_o    (out_wr),
		.out_data_o  (out_data),
		.mem_we_o    (mem_we),
		.mem_waddr_o (mem_waddr),
		.mem_wdata_o (mem_wdata),
		.mem_raddr_o (mem_raddr),
		.mem_rdata_i (mem_rdata),
		.blocks_o    (blocks)
	);

	block_ram u_block_ram (
		.okClk   (okClk),
		.we_i    (mem_we),
		.waddr_i (mem_waddr),
		.wdata_i (mem_wdata),
		.raddr_i (mem_raddr),
		.rdata_o (mem_rdata)
	);

endmodule

//--- tb/pipe_assertions.sv
`include "fp_params.svh"

module pipe_assertions
	import mem_pkg::*;
(
	input logic        okClk,
	input logic        rst_n_i,
	input logic        psel_i,
	input logic        penable_i,
	input logic        pi_write_i,
	input logic        po_read_i,
	input fifo_count_t in_count_i,
	input fifo_count_t out_count_i
);

	localparam fifo_count_t FIFO_FULL = fifo_count_t'(`FP_FIFO_DEPTH);

	// ----------------------------------------
	// Host pipe rules
	// ----------------------------------------
	pi_no_overflow: assert property (@(posedge okClk) disable iff (!rst_n_i)
		pi_write_i |-> (in_count_i != FIFO_FULL))
		else $error("pipe in written while the input FIFO is full");

	po_no_underflow: assert property (@(posedge okClk) disable iff (!rst_n_i)
		po_read_i |-> (out_count_i != '0))
		else $error("pipe out read while the output FIFO is empty");

	// Access phase needs a setup cycle right before it
	apb_setup_first: assert property (@(posedge okClk) disable iff (!rst_n_i)
		penable_i |-> $past(psel_i && !penable_i))
		else $error("APB access cycle without a setup cycle");

endmodule

bind pipe_top pipe_assertions u_pipe_assertions (
	.okClk       (okClk),
	.rst_n_i     (rst_n_i),
	.psel_i      (psel_i),
	.penable_i   (penable_i),
	.pi_write_i  (pi_write_i),
	.po_read_i   (po_read_i),
	.in_count_i  (in_count),
	.out_count_i (out_count)
);

//--- tb/tb_pipe_top.sv
`include "fp_params.svh"

module tb_pipe_top
	import host_pkg::*;
	import mem_pkg::*;
();

	localparam int BLK = `FP_BLOCK_SIZE;
	// About 700 cycles of traffic and status polling with a wide margin
	localparam int MAX_CYCLES = 20000;
	localparam int MAX_POLLS = 400;
	localparam int QUARTER = 10;   // Sample point after a falling edge

	logic      okClk;
	logic      rst_n_i;
	logic      psel_i;
	logic      penable_i;
	logic      pwrite_i;
	reg_addr_t paddr_i;
	apb_data_t pwdata_i;
	apb_data_t prdata_o;
	logic      pready_o;
	logic      pi_write_i;
	word_t     pi_data_i;
	logic      po_read_i;
	logic      pi_ready_o;
	word_t     po_data_o;
	logic      po_ready_o;

	word_t     sent_q[$];   // Words in flight in send order
	integer    seed = 32'h6e46b6cc;
	int        err_count = 0;
	int        pass_count = 0;
	int        fail_count = 0;
	int        test_err_base = 0;
	int        rx_count = 0;
	int        words_in = 0;
	int        cycle_cnt = 0;
	apb_data_t rd;

	pipe_top DUT (.*);

	initial okClk = 1'b0;
	always #20 okClk = ~okClk;

	// ----------------------------------------
	// Timeout and output compare
	// ----------------------------------------
	always @(posedge okClk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	always @(posedge okClk) begin : compare_proc
		word_t exp_word;
		if (rst_n_i && po_read_i) begin
			if (sent_q.size() == 0) begin
				err_count = err_count + 1;
				$display("Pipe out was read with no word left to compare at %0t", $time);
			end else begin
				exp_word = sent_q.pop_front();
				check_value("po_data_o", po_data_o, exp_word);
				rx_count = rx_count + 1;
			end
		end
	end

	// ----------------------------------------
	// Reference model and checks
	// ----------------------------------------
	function automatic apb_data_t expected_status(int written, int stored, int fetched,
			int words_read);
		int in_cnt;
		int out_cnt;
		int held;
		apb_data_t status;
		in_cnt  = written - BLK * stored;   // Not yet moved to the buffer
		out_cnt = BLK * fetched - words_read;
		held    = stored - fetched;
		status = '0;
		status[6:0]   = 7'(in_cnt);
		status[14:8]  = 7'(out_cnt);
		status[18:16] = 3'(held);
		return status;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		if (err_count == test_err_base) begin
			pass_count = pass_count + 1;
			$display("Test %s: passed", name);
		end else begin
			fail_count = fail_count + 1;
			$display("Test %s: failed with %0d errors", name, err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	// ----------------------------------------
	// Bus and pipe drivers
	// ----------------------------------------
	task automatic apb_write(input reg_addr_t addr, input apb_data_t data);
		@(negedge okClk);
		psel_i    = 1'b1;   // Setup
		penable_i = 1'b0;
		pwrite_i  = 1'b1;
		paddr_i   = addr;
		pwdata_i  = data;
		@(negedge okClk);
		penable_i = 1'b1;   // Access
		@(negedge okClk);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic apb_read(input reg_addr_t addr, output apb_data_t data);
		@(negedge okClk);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = addr;
		@(negedge okClk);
		penable_i = 1'b1;
		#QUARTER data = prdata_o;   // Before the access edge
		check_value("pready_o in access", 32'(pready_o), 32'd1);
		@(negedge okClk);
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic send_words(input int n);
		repeat (n) begin
			@(negedge okClk);
			pi_write_i = 1'b1;
			pi_data_i  = $random(seed);
			sent_q.push_back(pi_data_i);
			words_in = words_in + 1;
		end
		@(negedge okClk);
		pi_write_i = 1'b0;
	endtask

	task automatic send_block();
		@(negedge okClk);   // Idle cycle so the throttle catches up
		while (!pi_ready_o)
			@(negedge okClk);
		send_words(BLK);
	endtask

	task automatic read_block();
		@(negedge okClk);
		while (!po_ready_o)
			@(negedge okClk);
		repeat (BLK) begin
			po_read_i = 1'b1;
			@(negedge okClk);
		end
		po_read_i = 1'b0;
	endtask

	task automatic wait_status(input apb_data_t exp, input string what);
		int polls;
		apb_data_t status;
		polls = 0;
		apb_read(`FP_REG_STATUS, status);
		while (status !== exp && polls < MAX_POLLS) begin
			apb_read(`FP_REG_STATUS, status);
			polls = polls + 1;
		end
		check_value(what, status, exp);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	initial begin
		rst_n_i    = 1'b0;
		psel_i     = 1'b0;
		penable_i  = 1'b0;
		pwrite_i   = 1'b0;
		paddr_i    = '0;
		pwdata_i   = '0;
		pi_write_i = 1'b0;
		pi_data_i  = '0;
		po_read_i  = 1'b0;
		repeat (4) @(negedge okClk);
		rst_n_i = 1'b1;

		apb_read(`FP_REG_CTRL, rd);
		check_value("CTRL after reset", rd, 32'd0);
		apb_read(`FP_REG_STATUS, rd);
		check_value("STATUS after reset", rd, expected_status(0, 0, 0, 0));
		check_value("pi_ready_o after reset", 32'(pi_ready_o), 32'd1);
		check_value("po_ready_o after reset", 32'(po_ready_o), 32'd0);
		apb_write(`FP_REG_CTRL, 32'h1);
		apb_read(`FP_REG_CTRL, rd);
		check_value("CTRL readback reads_en", rd, 32'h1);
		apb_write(`FP_REG_CTRL, 32'h2);
		apb_read(`FP_REG_CTRL, rd);
		check_value("CTRL readback writes_en", rd, 32'h2);
		apb_write(`FP_REG_CTRL, 32'h0);
		finish_test("reset");

		repeat (3) send_block();   // Words stay in the FIFO while writes are off
		repeat (2) @(negedge okClk);
		check_value("pi_ready_o at 48 words", 32'(pi_ready_o), 32'd0);
		apb_read(`FP_REG_STATUS, rd);
		check_value("STATUS with writes off", rd, expected_status(words_in, 0, 0, 0));
		finish_test("throttle");

		apb_write(`FP_REG_CTRL, 32'h2);
		wait_status(expected_status(words_in, 3, 0, 0), "STATUS after store");
		finish_test("store");

		repeat (2) send_block();   // Fifth block finds the buffer full
		wait_status(expected_status(words_in, 4, 0, 0), "STATUS with buffer full");
		finish_test("buffer overflow");

		apb_write(`FP_REG_CTRL, 32'h3);
		while (rx_count < 5 * BLK)
			read_block();
		wait_status(expected_status(words_in, 5, 5, rx_count), "STATUS after drain");
		check_value("words left in queue", sent_q.size(), 32'd0);
		check_value("po_ready_o after drain", 32'(po_ready_o), 32'd0);
		finish_test("round trip");

		send_block();
		send_words(5);
		while (!po_ready_o)
			@(negedge okClk);
		apb_write(`FP_REG_CTRL, 32'h7);
		apb_read(`FP_REG_CTRL, rd);
		check_value("CTRL with soft_reset", rd, 32'h7);
		apb_write(`FP_REG_CTRL, 32'h0);
		sent_q.delete();   // Cleared words never come out
		repeat (2) @(negedge okClk);
		apb_read(`FP_REG_STATUS, rd);
		check_value("STATUS after soft reset", rd, expected_status(0, 0, 0, 0));
		check_value("po_ready_o after soft reset", 32'(po_ready_o), 32'd0);
		finish_test("soft reset");

		$display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
		if (err_count == 0 && fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+rtl
rtl/host_pkg.sv
rtl/mem_pkg.sv
rtl/fifo_sync.sv
rtl/host_regs.sv
rtl/dma_engine.sv
rtl/block_ram.sv
rtl/pipe_top.sv
tb/pipe_assertions.sv
tb/tb_pipe_top.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_pipe_top
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
